// File: hdl/mover_settings.svh
`ifndef MOVER_SETTINGS_SVH
`define MOVER_SETTINGS_SVH

// packet slots and IDs
`define PKT_NUM         8
`define PKT_ID_W        3

// flits per slot and flit-count width
`define MAX_FLITS       4
`define FLITS_W         3

// slot base is pkt_id * MAX_FLITS
`define BUF_AW          5

`define FLIT_DATA_W     64
`define EMPTY_W         3

// read latency of the flit memory, strobe to data
`define BUF_LATENCY     2

`define STARTUP_CYCLES  16

`endif

// File: hdl/mover_pkg.sv
`default_nettype none
`include "mover_settings.svh"

package mover_pkg;

    // routing decision for one packet
    typedef enum logic [1:0] {
        FLAG_ETH  = 2'd0,
        FLAG_PCIE = 2'd1,
        FLAG_DROP = 2'd2
    } pkt_flag_t;

    // one word per packet, flits counts 1 to MAX_FLITS
    typedef struct packed {
        logic [`PKT_ID_W-1:0] pkt_id;
        logic [`FLITS_W-1:0]  flits;
        pkt_flag_t            flag;
    } metadata_t;

    typedef struct packed {
        logic                    sop;
        logic                    eop;
        logic [`EMPTY_W-1:0]     empty;
        logic [`FLIT_DATA_W-1:0] data;
    } flit_t;

    typedef enum logic [2:0] {
        WAIT_STARTUP,
        INIT,
        IDLE,
        FIRST,
        MIDDLE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/flit_bus_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

// one flit per valid cycle, no ready
interface flit_bus_if;

    logic                    valid;
    logic                    sop;
    logic                    eop;
    logic [`EMPTY_W-1:0]     empty;
    logic [`FLIT_DATA_W-1:0] data;

    modport src (
        output valid,
        output sop,
        output eop,
        output empty,
        output data
    );

    modport dst (
        input valid,
        input sop,
        input eop,
        input empty,
        input data
    );

endinterface

`default_nettype wire

// File: hdl/pkt_buffer.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module pkt_buffer import mover_pkg::*; (
    input  wire                     clk,
    input  wire                     wr_en,
    input  wire [`BUF_AW-1:0]       wr_addr,
    input  wire flit_t              wr_flit,
    input  wire                     rd_en,
    input  wire [`BUF_AW-1:0]       rd_addr,
    flit_bus_if.src                 rd
);

    localparam int DEPTH = `PKT_NUM * `MAX_FLITS;

    flit_t                   mem [DEPTH];
    flit_t                   data_pipe [`BUF_LATENCY];
    // pipe starts empty at power-up
    logic [`BUF_LATENCY-1:0] vld_pipe = '0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_flit;
        end
    end

    // slow RAM model, stage 0 is the array read
    always_ff @(posedge clk) begin
        vld_pipe[0]  <= rd_en;
        data_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < `BUF_LATENCY; i++) begin
            vld_pipe[i]  <= vld_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rd.valid = vld_pipe[`BUF_LATENCY-1];
    assign rd.sop   = data_pipe[`BUF_LATENCY-1].sop;
    assign rd.eop   = data_pipe[`BUF_LATENCY-1].eop;
    assign rd.empty = data_pipe[`BUF_LATENCY-1].empty;
    assign rd.data  = data_pipe[`BUF_LATENCY-1].data;

endmodule

`default_nettype wire

// File: hdl/flag_delay.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module flag_delay import mover_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire pkt_flag_t  flag_in,
    output pkt_flag_t       flag_out
);

    pkt_flag_t dly [`BUF_LATENCY];

    // same depth as the buffer read pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BUF_LATENCY; i++) begin
                dly[i] <= FLAG_ETH;
            end
        end else begin
            dly[0] <= flag_in;
            for (int i = 1; i < `BUF_LATENCY; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    assign flag_out = dly[`BUF_LATENCY-1];

endmodule

`default_nettype wire

// File: hdl/free_list.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module free_list (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     push_valid,
    input  wire [`PKT_ID_W-1:0]     push_id,
    output logic                    free_valid,
    output logic [`PKT_ID_W-1:0]    free_id,
    input  wire                     free_pop
);

    localparam int CNT_W = `PKT_ID_W + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`PKT_NUM);

    logic [`PKT_ID_W-1:0] ids [`PKT_NUM];
    logic [`PKT_ID_W-1:0] wr_ptr;
    logic [`PKT_ID_W-1:0] rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;

    // pointers wrap on their own, PKT_NUM is 2**PKT_ID_W
    assign do_push    = push_valid & (count != FULL_CNT);
    assign do_pop     = free_pop & free_valid;
    assign free_valid = (count != '0);
    assign free_id    = ids[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            ids[wr_ptr] <= push_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/egress_router.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module egress_router import mover_pkg::*; (
    input  wire                         clk,
    input  wire                         rst,
    flit_bus_if.dst                     rd,
    input  wire pkt_flag_t              flag,
    output logic                        eth_valid,
    output logic                        eth_sop,
    output logic                        eth_eop,
    output logic [`EMPTY_W-1:0]         eth_empty,
    output logic [`FLIT_DATA_W-1:0]     eth_data,
    output logic                        pcie_valid,
    output logic                        pcie_sop,
    output logic                        pcie_eop,
    output logic [`EMPTY_W-1:0]         pcie_empty,
    output logic [`FLIT_DATA_W-1:0]     pcie_data
);

    logic pcie_hit;
    logic eth_hit;

    // anything not PCIe goes to ethernet
    assign pcie_hit = rd.valid & (flag == FLAG_PCIE);
    assign eth_hit  = rd.valid & (flag != FLAG_PCIE);

    always_ff @(posedge clk) begin
        if (rst) begin
            eth_valid  <= 1'b0;
            pcie_valid <= 1'b0;
        end else begin
            eth_valid  <= eth_hit;
            pcie_valid <= pcie_hit;
        end
    end

    always_ff @(posedge clk) begin
        eth_data   <= rd.data;
        pcie_data  <= rd.data;
        eth_sop    <= eth_hit & rd.sop;
        eth_eop    <= eth_hit & rd.eop;
        eth_empty  <= eth_hit ? rd.empty : '0;
        pcie_sop   <= pcie_hit & rd.sop;
        pcie_eop   <= pcie_hit & rd.eop;
        pcie_empty <= pcie_hit ? rd.empty : '0;
    end

endmodule

`default_nettype wire

// File: hdl/mover_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module mover_ctrl import mover_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     meta_valid,
    input  wire metadata_t          meta_data,
    output logic                    meta_ready,
    input  wire                     disable_pcie,
    input  wire                     eth_almost_full,
    input  wire                     pcie_almost_full,
    output logic                    rd_en,
    output logic [`BUF_AW-1:0]      rd_addr,
    output pkt_flag_t               cur_flag,
    output logic                    push_valid,
    output logic [`PKT_ID_W-1:0]    push_id,
    output logic                    pcie_meta_valid,
    output metadata_t               pcie_meta_data
);

    localparam int STARTUP_W = $clog2(`STARTUP_CYCLES);
    localparam logic [STARTUP_W-1:0] STARTUP_LAST = STARTUP_W'(`STARTUP_CYCLES - 1);
    localparam logic [`PKT_ID_W-1:0] LAST_ID = `PKT_ID_W'(`PKT_NUM - 1);

    ctrl_state_t          state;
    logic [STARTUP_W-1:0] startup_cnt;
    logic [`PKT_ID_W-1:0] init_id;
    metadata_t            cur_meta;
    logic [`FLITS_W-1:0]  flit_idx;
    logic                 almost_full;
    logic                 is_drop;
    logic                 last_flit;
    logic                 accept;

    assign almost_full = eth_almost_full | pcie_almost_full;
    assign is_drop     = (cur_meta.flag == FLAG_DROP);

    // last cycle of the current packet, a drop takes just one
    always_comb begin
        case (state)
            FIRST:   last_flit = is_drop | (cur_meta.flits == `FLITS_W'(1));
            MIDDLE:  last_flit = (flit_idx == cur_meta.flits - 1'b1);
            default: last_flit = 1'b0;
        endcase
    end

    assign meta_ready = ((state == IDLE) | last_flit) & ~almost_full;
    assign accept     = meta_valid & meta_ready;

    // no strobe while in reset, so the read pipe comes up empty
    assign rd_en   = ~rst & (((state == FIRST) & ~is_drop) | (state == MIDDLE));
    assign rd_addr = `BUF_AW'(cur_meta.pkt_id) * `BUF_AW'(`MAX_FLITS) + `BUF_AW'(flit_idx);
    assign cur_flag = cur_meta.flag;

    // init fill, then one push on the last strobe or the drop cycle
    assign push_valid = (state == INIT) | last_flit;
    assign push_id    = (state == INIT) ? init_id : cur_meta.pkt_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= WAIT_STARTUP;
            startup_cnt <= '0;
            init_id     <= '0;
            flit_idx    <= '0;
            cur_meta    <= '{pkt_id: '0, flits: '0, flag: FLAG_ETH};
        end else begin
            case (state)
                WAIT_STARTUP: begin
                    startup_cnt <= startup_cnt + 1'b1;
                    if (startup_cnt == STARTUP_LAST) begin
                        state <= INIT;
                    end
                end
                INIT: begin
                    init_id <= init_id + 1'b1;
                    if (init_id == LAST_ID) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        state <= FIRST;
                    end
                end
                FIRST, MIDDLE: begin
                    if (!last_flit) begin
                        state <= MIDDLE;
                    end else if (accept) begin
                        state <= FIRST;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (accept) begin
                cur_meta.pkt_id <= meta_data.pkt_id;
                cur_meta.flits  <= meta_data.flits;
                // disable_pcie reroutes everything that is not dropped
                if (disable_pcie && meta_data.flag != FLAG_DROP) begin
                    cur_meta.flag <= FLAG_ETH;
                end else begin
                    cur_meta.flag <= meta_data.flag;
                end
                flit_idx <= '0;
            end else if (rd_en) begin
                flit_idx <= flit_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcie_meta_valid <= 1'b0;
        end else begin
            pcie_meta_valid <= accept & (meta_data.flag == FLAG_PCIE) & ~disable_pcie;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pcie_meta_data <= meta_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/data_mover_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module data_mover_top import mover_pkg::*; (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en,
    input  wire [`BUF_AW-1:0]           wr_addr,
    input  wire flit_t                  wr_flit,
    input  wire                         meta_valid,
    input  wire metadata_t              meta_data,
    output logic                        meta_ready,
    input  wire                         disable_pcie,
    input  wire                         eth_almost_full,
    input  wire                         pcie_almost_full,
    output logic                        free_valid,
    output logic [`PKT_ID_W-1:0]        free_id,
    input  wire                         free_pop,
    output logic                        pcie_meta_valid,
    output metadata_t                   pcie_meta_data,
    output logic                        eth_valid,
    output logic                        eth_sop,
    output logic                        eth_eop,
    output logic [`EMPTY_W-1:0]         eth_empty,
    output logic [`FLIT_DATA_W-1:0]     eth_data,
    output logic                        pcie_valid,
    output logic                        pcie_sop,
    output logic                        pcie_eop,
    output logic [`EMPTY_W-1:0]         pcie_empty,
    output logic [`FLIT_DATA_W-1:0]     pcie_data
);

    logic                 rd_en;
    logic [`BUF_AW-1:0]   rd_addr;
    pkt_flag_t            cur_flag;
    pkt_flag_t            dly_flag;
    logic                 push_valid;
    logic [`PKT_ID_W-1:0] push_id;

    flit_bus_if flit_rd ();

    mover_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .meta_valid       (meta_valid),
        .meta_data        (meta_data),
        .meta_ready       (meta_ready),
        .disable_pcie     (disable_pcie),
        .eth_almost_full  (eth_almost_full),
        .pcie_almost_full (pcie_almost_full),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .cur_flag         (cur_flag),
        .push_valid       (push_valid),
        .push_id          (push_id),
        .pcie_meta_valid  (pcie_meta_valid),
        .pcie_meta_data   (pcie_meta_data)
    );

    pkt_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_flit (wr_flit),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd      (flit_rd.src)
    );

    // flag follows its flits through the read latency
    flag_delay u_flag_delay (
        .clk      (clk),
        .rst      (rst),
        .flag_in  (cur_flag),
        .flag_out (dly_flag)
    );

    free_list u_free_list (
        .clk        (clk),
        .rst        (rst),
        .push_valid (push_valid),
        .push_id    (push_id),
        .free_valid (free_valid),
        .free_id    (free_id),
        .free_pop   (free_pop)
    );

    egress_router u_router (
        .clk        (clk),
        .rst        (rst),
        .rd         (flit_rd.dst),
        .flag       (dly_flag),
        .eth_valid  (eth_valid),
        .eth_sop    (eth_sop),
        .eth_eop    (eth_eop),
        .eth_empty  (eth_empty),
        .eth_data   (eth_data),
        .pcie_valid (pcie_valid),
        .pcie_sop   (pcie_sop),
        .pcie_eop   (pcie_eop),
        .pcie_empty (pcie_empty),
        .pcie_data  (pcie_data)
    );

endmodule

`default_nettype wire

// File: tests/data_mover_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module data_mover_assert import mover_pkg::*; (
    input wire                  clk,
    input wire                  rst,
    input wire ctrl_state_t     state,
    input wire metadata_t       cur_meta,
    input wire                  rd_en,
    input wire [`BUF_AW-1:0]    rd_addr,
    input wire                  push_valid,
    input wire                  meta_ready,
    input wire                  eth_almost_full,
    input wire                  pcie_almost_full
);

    int slot_lo;
    int slot_hi;
    int since_rst;

    // address window of the packet being read
    assign slot_lo = int'(cur_meta.pkt_id) * `MAX_FLITS;
    assign slot_hi = slot_lo + int'(cur_meta.flits);

    // cycles since reset, held once the startup wait is over
    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= 0;
        end else if (since_rst < `STARTUP_CYCLES) begin
            since_rst <= since_rst + 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (since_rst < `STARTUP_CYCLES) |-> (state == WAIT_STARTUP && !rd_en && !push_valid))
        else $error("startup wait cut short, or a strobe or push during it");

    assert property (@(posedge clk) disable iff (rst)
        (eth_almost_full || pcie_almost_full) |-> !meta_ready ##1 (state != FIRST))
        else $error("new packet taken while an almost_full input is set");

    assert property (@(posedge clk) disable iff (rst)
        rd_en |-> (int'(rd_addr) >= slot_lo && int'(rd_addr) < slot_hi))
        else $error("rd_addr outside the slot of the accepted packet");

endmodule

bind mover_ctrl data_mover_assert u_assert (
    .clk              (clk),
    .rst              (rst),
    .state            (state),
    .cur_meta         (cur_meta),
    .rd_en            (rd_en),
    .rd_addr          (rd_addr),
    .push_valid       (push_valid),
    .meta_ready       (meta_ready),
    .eth_almost_full  (eth_almost_full),
    .pcie_almost_full (pcie_almost_full)
);

`default_nettype wire

// File: tests/data_mover_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mover_settings.svh"

module data_mover_tb import mover_pkg::*; ;

    localparam int TIMEOUT = 200;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     wr_en;
    logic [`BUF_AW-1:0]       wr_addr;
    flit_t                    wr_flit;
    logic                     meta_valid;
    metadata_t                meta_data;
    logic                     meta_ready;
    logic                     disable_pcie;
    logic                     eth_almost_full;
    logic                     pcie_almost_full;
    logic                     free_valid;
    logic [`PKT_ID_W-1:0]     free_id;
    logic                     free_pop;
    logic                     pcie_meta_valid;
    metadata_t                pcie_meta_data;
    logic                     eth_valid;
    logic                     eth_sop;
    logic                     eth_eop;
    logic [`EMPTY_W-1:0]      eth_empty;
    logic [`FLIT_DATA_W-1:0]  eth_data;
    logic                     pcie_valid;
    logic                     pcie_sop;
    logic                     pcie_eop;
    logic [`EMPTY_W-1:0]      pcie_empty;
    logic [`FLIT_DATA_W-1:0]  pcie_data;

    logic [31:0] lcg_state;
    flit_t       slot_flits [`PKT_NUM][`MAX_FLITS];
    flit_t       eth_q[$];
    flit_t       pcie_q[$];
    metadata_t   meta_q[$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    data_mover_top UUT (.*);

    always #50 clk = ~clk;

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (eth_valid) eth_q.push_back(flit_t'({eth_sop, eth_eop, eth_empty, eth_data}));
        if (pcie_valid) pcie_q.push_back(flit_t'({pcie_sop, pcie_eop, pcie_empty, pcie_data}));
        if (pcie_meta_valid) meta_q.push_back(pcie_meta_data);
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic metadata_t make_meta(input int id, input int n, input pkt_flag_t f);
        metadata_t m;
        m.pkt_id = `PKT_ID_W'(id);
        m.flits  = `FLITS_W'(n);
        m.flag   = f;
        return m;
    endfunction

    task automatic compare(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) $display("test %-16s ok", name);
        else $display("test %-16s %0d errors", name, errors - errors_before);
    endtask

    // writes a packet into its slot and keeps a copy for checking
    task automatic load_packet(input int id, input int nflits);
        flit_t       f;
        logic [31:0] r;
        int          i;
        for (i = 0; i < nflits; i++) begin
            r       = lcg_next();
            f.sop   = (i == 0);
            f.eop   = (i == nflits - 1);
            f.empty = f.eop ? r[`EMPTY_W-1:0] : '0;
            f.data  = {lcg_next(), lcg_next()};
            slot_flits[id][i] = f;
            wr_en   = 1'b1;
            wr_addr = `BUF_AW'(id * `MAX_FLITS + i);
            wr_flit = f;
            @(negedge clk);
        end
        wr_en = 1'b0;
    endtask

    task automatic send_meta(input metadata_t m);
        int n;
        n = 0;
        meta_valid = 1'b1;
        meta_data  = m;
        #1;
        while (!meta_ready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!meta_ready) begin
            errors++;
            $display("timeout: metadata for packet %0d was never accepted", m.pkt_id);
        end
        @(negedge clk);
        meta_valid = 1'b0;
    endtask

    task automatic pop_id(output logic [`PKT_ID_W-1:0] id);
        int n;
        n = 0;
        while (!free_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!free_valid) begin
            errors++;
            $display("timeout: free list never offered an ID");
            id = 'x;
        end else begin
            id = free_id;
            free_pop = 1'b1;
            @(negedge clk);
            free_pop = 1'b0;
        end
    endtask

    task automatic expect_packet(input bit on_pcie, input int id, input int nflits);
        int    n;
        int    i;
        flit_t got;
        n = 0;
        while ((on_pcie ? pcie_q.size() : eth_q.size()) < nflits && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if ((on_pcie ? pcie_q.size() : eth_q.size()) < nflits) begin
            errors++;
            $display("timeout: packet %0d did not arrive complete", id);
        end else begin
            for (i = 0; i < nflits; i++) begin
                if (on_pcie) got = pcie_q.pop_front();
                else got = eth_q.pop_front();
                compare(on_pcie ? "pcie flit" : "eth flit", got, slot_flits[id][i]);
            end
        end
        @(negedge clk);
    endtask

    // a short window in which nothing else may come out
    task automatic check_quiet();
        repeat (4) @(posedge clk);
        compare("eth flit count", eth_q.size(), 0);
        compare("pcie flit count", pcie_q.size(), 0);
        compare("pcie_meta_valid count", meta_q.size(), 0);
        @(negedge clk);
    endtask

    task automatic free_list_fill();
        int                   e0;
        int                   n;
        int                   i;
        logic [`PKT_ID_W-1:0] id;
        e0 = errors;
        n = 0;
        while (!meta_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!meta_ready) begin
            errors++;
            $display("timeout: controller never left startup");
        end
        for (i = 0; i < `PKT_NUM; i++) begin
            pop_id(id);
            compare("free_id", id, i);
        end
        compare("free_valid", free_valid, 1'b0);
        report_test("free-list fill", e0);
    endtask

    task automatic eth_packet();
        int                   e0;
        logic [`PKT_ID_W-1:0] id;
        e0 = errors;
        load_packet(2, 3);
        send_meta(make_meta(2, 3, FLAG_ETH));
        expect_packet(1'b0, 2, 3);
        pop_id(id);
        compare("free_id", id, 2);
        check_quiet();
        report_test("ethernet", e0);
    endtask

    task automatic pcie_packets();
        int                   e0;
        logic [`PKT_ID_W-1:0] id;
        e0 = errors;
        load_packet(5, 2);
        load_packet(6, 4);
        send_meta(make_meta(5, 2, FLAG_PCIE));
        send_meta(make_meta(6, 4, FLAG_PCIE));
        expect_packet(1'b1, 5, 2);
        expect_packet(1'b1, 6, 4);
        compare("pcie_meta_valid count", meta_q.size(), 2);
        if (meta_q.size() == 2) begin
            compare("pcie_meta_data", meta_q.pop_front(), make_meta(5, 2, FLAG_PCIE));
            compare("pcie_meta_data", meta_q.pop_front(), make_meta(6, 4, FLAG_PCIE));
        end
        pop_id(id);
        compare("free_id", id, 5);
        pop_id(id);
        compare("free_id", id, 6);
        check_quiet();
        report_test("pcie", e0);
    endtask

    task automatic dropped_packet();
        int                   e0;
        logic [`PKT_ID_W-1:0] id;
        e0 = errors;
        send_meta(make_meta(3, 2, FLAG_DROP));
        pop_id(id);
        compare("free_id", id, 3);
        check_quiet();
        report_test("drop", e0);
    endtask

    task automatic pcie_disabled();
        int                   e0;
        logic [`PKT_ID_W-1:0] id;
        e0 = errors;
        load_packet(1, 4);
        disable_pcie = 1'b1;
        send_meta(make_meta(1, 4, FLAG_PCIE));
        expect_packet(1'b0, 1, 4);
        disable_pcie = 1'b0;
        pop_id(id);
        compare("free_id", id, 1);
        check_quiet();
        report_test("disable_pcie", e0);
    endtask

    task automatic almost_full_stall();
        int                   e0;
        logic [`PKT_ID_W-1:0] id;
        e0 = errors;
        load_packet(4, 3);
        eth_almost_full = 1'b1;
        meta_valid = 1'b1;
        meta_data  = make_meta(4, 3, FLAG_ETH);
        repeat (8) begin
            @(posedge clk);
            compare("eth flit count", eth_q.size(), 0);
            @(negedge clk);
            compare("meta_ready", meta_ready, 1'b0);
        end
        // the PCIe side stalls new packets the same way
        eth_almost_full  = 1'b0;
        pcie_almost_full = 1'b1;
        repeat (4) begin
            @(posedge clk);
            compare("eth flit count", eth_q.size(), 0);
            @(negedge clk);
            compare("meta_ready", meta_ready, 1'b0);
        end
        pcie_almost_full = 1'b0;
        send_meta(make_meta(4, 3, FLAG_ETH));
        expect_packet(1'b0, 4, 3);
        pop_id(id);
        compare("free_id", id, 4);
        check_quiet();
        report_test("almost-full stall", e0);
    endtask

    initial begin
        rst              = 1'b1;
        wr_en            = 1'b0;
        wr_addr          = '0;
        wr_flit          = '0;
        meta_valid       = 1'b0;
        meta_data        = '0;
        disable_pcie     = 1'b0;
        eth_almost_full  = 1'b0;
        pcie_almost_full = 1'b0;
        free_pop         = 1'b0;
        lcg_state        = 32'hd87b;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        free_list_fill();
        eth_packet();
        pcie_packets();
        dropped_packet();
        pcie_disabled();
        almost_full_stall();
        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/mover_pkg.sv
hdl/flit_bus_if.sv
hdl/pkt_buffer.sv
hdl/flag_delay.sv
hdl/free_list.sv
hdl/egress_router.sv
hdl/mover_ctrl.sv
hdl/data_mover_top.sv
tests/data_mover_assert.sv
tests/data_mover_tb.sv
